//--- vlog.f
hdl/vls_pkg.sv
hdl/axi_burst_pkg.sv
hdl/vls_req_decode.sv
hdl/axi_burst_split.sv
hdl/addr_req_queue.sv
hdl/vls_addrgen.sv
testbench/tb_vls_addrgen.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal
TOP        ?= tb_vls_addrgen
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass string shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_vls_addrgen.sv
// ========================================
// Testbench for the vector address generator
// Checks AR/AW bursts, queue entries and acks
// ========================================

`timescale 1ns/1ps

module tb_vls_addrgen;

  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned QueueDepth   = 4;
  localparam int unsigned BeatBytes    = AxiDataWidth / 8;
  localparam int unsigned SizeLog      = $clog2(BeatBytes);
  // Expected handling of a request
  localparam int Accept = 0;
  localparam int Reject = 1;
  localparam int Ignore = 2;

  logic                                clk_i, rst_ni, pe_req_valid_i, core_st_pending_i;
  logic [$clog2(vls_pkg::NrVInsn)-1:0] pe_req_id_i;
  vls_pkg::vls_op_e                    pe_req_op_i;
  logic [AxiAddrWidth-1:0]             pe_req_addr_i;
  logic [vls_pkg::VlWidth-1:0]         pe_req_vl_i;
  vls_pkg::vew_e                       pe_req_vew_i;
  logic [vls_pkg::NrVInsn-1:0]         vinsn_running_i;
  logic                                addrgen_ack_o, addrgen_error_o;
  logic [AxiAddrWidth-1:0]             axi_ar_addr_o, axi_aw_addr_o, axi_addrgen_req_addr_o;
  logic [7:0]                          axi_ar_len_o, axi_aw_len_o, axi_addrgen_req_len_o;
  logic [2:0]                          axi_ar_size_o, axi_aw_size_o, axi_addrgen_req_size_o;
  axi_burst_pkg::burst_e               axi_ar_burst_o, axi_aw_burst_o;
  logic [3:0]                          axi_ar_cache_o, axi_aw_cache_o;
  logic                                axi_ar_valid_o, axi_ar_ready_i;
  logic                                axi_aw_valid_o, axi_aw_ready_i;
  logic                                axi_addrgen_req_valid_o, axi_addrgen_req_is_load_o;
  logic                                ldu_req_ready_i, stu_req_ready_i;

  // Expected bursts kept once for AR/AW and once for the queue
  logic [AxiAddrWidth-1:0] exp_ax_addr[$], exp_q_addr[$];
  logic [7:0]              exp_ax_len[$], exp_q_len[$];
  logic                    exp_ax_load[$], exp_q_load[$], exp_ack_err[$];
  int                      cycles, burst_total, ax_xfers, acks_seen, base;
  integer                  seed;
  logic                    hold_units;

  vls_addrgen #(
    .AxiDataWidth(AxiDataWidth),
    .AxiAddrWidth(AxiAddrWidth),
    .QueueDepth  (QueueDepth)
  ) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Random back-pressure on AR/AW and on the units once reset is released
  initial begin
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      axi_ar_ready_i  = ($random(seed) & 3) != 0;
      axi_aw_ready_i  = ($random(seed) & 3) != 0;
      ldu_req_ready_i = !hold_units && (($random(seed) & 1) != 0);
      stu_req_ready_i = !hold_units && (($random(seed) & 3) == 0);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic compare_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error %s: got 0x%0h, expected 0x%0h", sig, got, exp));
    end
  endtask

  task automatic check_burst(input string chan, input logic is_load,
                             input logic [AxiAddrWidth-1:0] addr, input logic [7:0] len,
                             input logic [2:0] size, input axi_burst_pkg::burst_e burst,
                             input logic [3:0] cache);
    if (exp_ax_addr.size() == 0) begin
      abort_run({"Burst on ", chan, " that no instruction asked for"});
    end
    if (is_load !== exp_ax_load[0]) begin
      abort_run({"Burst went out on the wrong channel ", chan});
    end
    compare_value({chan, "_addr_o"}, addr, exp_ax_addr[0]);
    compare_value({chan, "_len_o"}, 32'(len), 32'(exp_ax_len[0]));
    compare_value({chan, "_size_o"}, 32'(size), SizeLog);
    compare_value({chan, "_burst_o"}, 32'(burst), 32'(axi_burst_pkg::BURST_INCR));
    compare_value({chan, "_cache_o"}, 32'(cache), 32'(axi_burst_pkg::CacheModifiable));
    void'(exp_ax_addr.pop_front());
    void'(exp_ax_len.pop_front());
    void'(exp_ax_load.pop_front());
  endtask

  task automatic check_queue_entry(input logic [AxiAddrWidth-1:0] addr, input logic [7:0] len,
                                   input logic [2:0] size, input logic is_load);
    if (exp_q_addr.size() == 0) begin
      abort_run("Queue presented an entry that no burst produced");
    end
    compare_value("axi_addrgen_req_addr_o", addr, exp_q_addr[0]);
    compare_value("axi_addrgen_req_len_o", 32'(len), 32'(exp_q_len[0]));
    compare_value("axi_addrgen_req_size_o", 32'(size), SizeLog);
    compare_value("axi_addrgen_req_is_load_o", 32'(is_load), 32'(exp_q_load[0]));
    void'(exp_q_addr.pop_front());
    void'(exp_q_len.pop_front());
    void'(exp_q_load.pop_front());
  endtask

  task automatic check_ack(input logic ack, input logic err);
    if (exp_ack_err.size() == 0) begin
      abort_run("Acknowledge without a pending instruction");
    end
    compare_value("addrgen_ack_o", 32'(ack), 32'd1);
    compare_value("addrgen_error_o", 32'(err), 32'(exp_ack_err[0]));
    if (!err && exp_ax_addr.size() != 0) begin
      abort_run("Acknowledge came before the last burst was sent");
    end
    void'(exp_ack_err.pop_front());
  endtask

  // Expected bursts cut at the page end, at 256 beats or at the end of the data
  function automatic void expect_bursts(input logic [31:0] addr, input int vl, input int vew,
                                        input logic is_load);
    longint a, rem, e, b, aligned, last, lim, used;
    a   = addr;
    rem = vl;
    e   = longint'(1) << vew;
    b   = BeatBytes;
    while (rem > 0) begin
      aligned = (a / b) * b;
      last    = (a / 4096) * 4096 + 4095;
      lim     = aligned + 256 * b - 1;
      if (lim < last) last = lim;
      lim = ((a + rem * e - 1) / b) * b + b - 1;
      if (lim < last) last = lim;
      exp_ax_addr.push_back(a[31:0]);
      exp_ax_len.push_back(8'((last - aligned + 1) / b - 1));
      exp_ax_load.push_back(is_load);
      exp_q_addr.push_back(a[31:0]);
      exp_q_len.push_back(8'((last - aligned + 1) / b - 1));
      exp_q_load.push_back(is_load);
      used = (last - a + 1) / e;
      rem  = (used >= rem) ? 0 : rem - used;
      a    = last + 1;
      burst_total++;
    end
  endfunction

  // Transfers, pops and acks are sampled where outputs are settled
  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycles++;
      if (cycles > 40 * burst_total + 200) begin
        abort_run($sformatf("Timeout after %0d cycles with work still pending", cycles));
      end
      if (axi_ar_valid_o && axi_ar_ready_i) begin
        check_burst("axi_ar", 1'b1, axi_ar_addr_o, axi_ar_len_o, axi_ar_size_o,
                    axi_ar_burst_o, axi_ar_cache_o);
        ax_xfers++;
      end
      if (axi_aw_valid_o && axi_aw_ready_i) begin
        check_burst("axi_aw", 1'b0, axi_aw_addr_o, axi_aw_len_o, axi_aw_size_o,
                    axi_aw_burst_o, axi_aw_cache_o);
        ax_xfers++;
      end
      if (axi_addrgen_req_valid_o && (ldu_req_ready_i || stu_req_ready_i)) begin
        check_queue_entry(axi_addrgen_req_addr_o, axi_addrgen_req_len_o,
                          axi_addrgen_req_size_o, axi_addrgen_req_is_load_o);
      end
      if (addrgen_ack_o || addrgen_error_o) begin
        check_ack(addrgen_ack_o, addrgen_error_o);
        acks_seen++;
      end
    end
  end

  task automatic issue(input logic [2:0] id, input vls_pkg::vls_op_e op, input logic [31:0] addr,
                       input logic [15:0] vl, input vls_pkg::vew_e vew, input int kind);
    @(negedge clk_i);
    if (kind == Accept) expect_bursts(addr, int'(vl), int'(vew), op == vls_pkg::VLE);
    if (kind != Ignore) exp_ack_err.push_back(kind == Reject);
    pe_req_valid_i      = 1'b1;
    pe_req_id_i         = id;
    pe_req_op_i         = op;
    pe_req_addr_i       = addr;
    pe_req_vl_i         = vl;
    pe_req_vew_i        = vew;
    vinsn_running_i[id] = 1'b1;
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
  endtask

  // Wait for the acknowledge and let the sequencer retire the ID unless it is kept
  task automatic wait_ack(input logic [2:0] id, input logic keep);
    int seen;
    seen = acks_seen;
    while (acks_seen == seen) @(negedge clk_i);
    if (!keep) vinsn_running_i[id] = 1'b0;
  endtask

  task automatic drain_queue();
    while (exp_q_addr.size() != 0) @(negedge clk_i);
  endtask

  initial begin
    seed = 6;
    cycles = 0;
    burst_total = 0;
    ax_xfers = 0;
    acks_seen = 0;
    hold_units = 1'b0;
    rst_ni = 1'b0;
    pe_req_valid_i = 1'b0;
    pe_req_id_i = '0;
    pe_req_op_i = vls_pkg::VNOP;
    pe_req_addr_i = '0;
    pe_req_vl_i = '0;
    pe_req_vew_i = vls_pkg::EW8;
    vinsn_running_i = '0;
    core_st_pending_i = 1'b0;
    axi_ar_ready_i = 1'b0;
    axi_aw_ready_i = 1'b0;
    ldu_req_ready_i = 1'b0;
    stu_req_ready_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Single burst loads with ID 1 kept running for the last test
    issue(3'd1, vls_pkg::VLE, 32'h0000_1040, 16'd20, vls_pkg::EW32, Accept);
    wait_ack(3'd1, 1'b1);
    issue(3'd4, vls_pkg::VLE, 32'h0000_4006, 16'd7, vls_pkg::EW16, Accept);
    wait_ack(3'd4, 1'b0);
    // Store across a page boundary
    issue(3'd2, vls_pkg::VSE, 32'h0000_2FC0, 16'd32, vls_pkg::EW64, Accept);
    wait_ack(3'd2, 1'b0);
    // More than 256 beats inside one page
    issue(3'd3, vls_pkg::VLE, 32'h0001_0000, 16'd300, vls_pkg::EW64, Accept);
    wait_ack(3'd3, 1'b0);
    // Misaligned base, then strided and indexed opcodes
    issue(3'd5, vls_pkg::VSE, 32'h0000_5002, 16'd8, vls_pkg::EW32, Reject);
    wait_ack(3'd5, 1'b0);
    issue(3'd5, vls_pkg::VLSE, 32'h0000_5000, 16'd8, vls_pkg::EW8, Reject);
    wait_ack(3'd5, 1'b0);
    issue(3'd5, vls_pkg::VSXE, 32'h0000_5000, 16'd8, vls_pkg::EW8, Reject);
    wait_ack(3'd5, 1'b0);

    // Core store pending holds back the bursts
    @(negedge clk_i);
    core_st_pending_i = 1'b1;
    issue(3'd6, vls_pkg::VLE, 32'h0000_6FF0, 16'd40, vls_pkg::EW8, Accept);
    repeat (10) begin
      @(posedge clk_i);
      if (axi_ar_valid_o || axi_aw_valid_o) begin
        abort_run("Burst request raised while a core store was pending");
      end
    end
    @(negedge clk_i);
    core_st_pending_i = 1'b0;
    wait_ack(3'd6, 1'b0);

    // Both units stalled so the queue fills and traffic stops
    drain_queue();
    @(posedge clk_i);
    hold_units = 1'b1;
    base = ax_xfers;
    issue(3'd7, vls_pkg::VLE, 32'h0000_8000, 16'd1536, vls_pkg::EW64, Accept);
    while (ax_xfers - base < int'(QueueDepth)) @(negedge clk_i);
    repeat (20) begin
      @(posedge clk_i);
      if (axi_ar_valid_o || axi_aw_valid_o) begin
        abort_run("Burst request raised while the descriptor queue was full");
      end
    end
    @(posedge clk_i);
    hold_units = 1'b0;
    wait_ack(3'd7, 1'b0);

    // Strobe with an ID that is still running
    base = acks_seen;
    issue(3'd1, vls_pkg::VLE, 32'h0000_1040, 16'd20, vls_pkg::EW32, Ignore);
    repeat (20) @(negedge clk_i);
    if (acks_seen != base) abort_run("Strobe with a running ID was acknowledged");
    vinsn_running_i[1] = 1'b0;

    drain_queue();
    if (exp_ax_addr.size() != 0 || exp_ack_err.size() != 0) begin
      abort_run("Expected bursts or acknowledges never appeared");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- hdl/vls_addrgen.sv
// ======================================
// Vector load/store address generator
// Decode, burst split and descriptor queue
// ======================================

`timescale 1ns/1ps

module vls_addrgen #(
  parameter int unsigned AxiDataWidth = 64,
  parameter int unsigned AxiAddrWidth = 32,
  parameter int unsigned QueueDepth   = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Sequencer
  input  logic                               pe_req_valid_i,
  input  logic [$clog2(vls_pkg::NrVInsn)-1:0] pe_req_id_i,
  input  vls_pkg::vls_op_e                   pe_req_op_i,
  input  logic [AxiAddrWidth-1:0]            pe_req_addr_i,
  input  logic [vls_pkg::VlWidth-1:0]        pe_req_vl_i,
  input  vls_pkg::vew_e                      pe_req_vew_i,
  input  logic [vls_pkg::NrVInsn-1:0]        vinsn_running_i,
  output logic                               addrgen_ack_o,
  output logic                               addrgen_error_o,
  input  logic                               core_st_pending_i,
  // AR channel
  output logic [AxiAddrWidth-1:0]            axi_ar_addr_o,
  output logic [7:0]                         axi_ar_len_o,
  output logic [2:0]                         axi_ar_size_o,
  output axi_burst_pkg::burst_e              axi_ar_burst_o,
  output logic [3:0]                         axi_ar_cache_o,
  output logic                               axi_ar_valid_o,
  input  logic                               axi_ar_ready_i,
  // AW channel
  output logic [AxiAddrWidth-1:0]            axi_aw_addr_o,
  output logic [7:0]                         axi_aw_len_o,
  output logic [2:0]                         axi_aw_size_o,
  output axi_burst_pkg::burst_e              axi_aw_burst_o,
  output logic [3:0]                         axi_aw_cache_o,
  output logic                               axi_aw_valid_o,
  input  logic                               axi_aw_ready_i,
  // Load/store units
  output logic                               axi_addrgen_req_valid_o,
  output logic [AxiAddrWidth-1:0]            axi_addrgen_req_addr_o,
  output logic [7:0]                         axi_addrgen_req_len_o,
  output logic [2:0]                         axi_addrgen_req_size_o,
  output logic                               axi_addrgen_req_is_load_o,
  input  logic                               ldu_req_ready_i,
  input  logic                               stu_req_ready_i
);

  // Decode to split
  logic                        cmd_valid;
  logic [AxiAddrWidth-1:0]     cmd_addr;
  logic [vls_pkg::VlWidth-1:0] cmd_vl;
  vls_pkg::vew_e               cmd_vew;
  logic                        cmd_is_load;
  logic                        cmd_done;

  // Split to queue
  logic                    q_push;
  logic                    q_full;
  logic [AxiAddrWidth-1:0] q_addr;
  logic [7:0]              q_len;
  logic [2:0]              q_size;

  vls_req_decode #(
    .AxiAddrWidth(AxiAddrWidth)
  ) i_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_id_i    (pe_req_id_i),
    .pe_req_op_i    (pe_req_op_i),
    .pe_req_addr_i  (pe_req_addr_i),
    .pe_req_vl_i    (pe_req_vl_i),
    .pe_req_vew_i   (pe_req_vew_i),
    .vinsn_running_i(vinsn_running_i),
    .cmd_done_i     (cmd_done),
    .cmd_valid_o    (cmd_valid),
    .cmd_addr_o     (cmd_addr),
    .cmd_vl_o       (cmd_vl),
    .cmd_vew_o      (cmd_vew),
    .cmd_is_load_o  (cmd_is_load),
    .addrgen_ack_o  (addrgen_ack_o),
    .addrgen_error_o(addrgen_error_o)
  );

  axi_burst_split #(
    .AxiDataWidth(AxiDataWidth),
    .AxiAddrWidth(AxiAddrWidth)
  ) i_split (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cmd_valid_i      (cmd_valid),
    .cmd_addr_i       (cmd_addr),
    .cmd_vl_i         (cmd_vl),
    .cmd_vew_i        (cmd_vew),
    .cmd_is_load_i    (cmd_is_load),
    .cmd_done_o       (cmd_done),
    .core_st_pending_i(core_st_pending_i),
    .q_full_i         (q_full),
    .q_push_o         (q_push),
    .axi_ar_addr_o    (axi_ar_addr_o),
    .axi_ar_len_o     (axi_ar_len_o),
    .axi_ar_size_o    (axi_ar_size_o),
    .axi_ar_burst_o   (axi_ar_burst_o),
    .axi_ar_cache_o   (axi_ar_cache_o),
    .axi_ar_valid_o   (axi_ar_valid_o),
    .axi_ar_ready_i   (axi_ar_ready_i),
    .axi_aw_addr_o    (axi_aw_addr_o),
    .axi_aw_len_o     (axi_aw_len_o),
    .axi_aw_size_o    (axi_aw_size_o),
    .axi_aw_burst_o   (axi_aw_burst_o),
    .axi_aw_cache_o   (axi_aw_cache_o),
    .axi_aw_valid_o   (axi_aw_valid_o),
    .axi_aw_ready_i   (axi_aw_ready_i)
  );

  // The AR fields carry the burst for loads and stores alike
  assign q_addr = axi_ar_addr_o;
  assign q_len  = axi_ar_len_o;
  assign q_size = axi_ar_size_o;

  addr_req_queue #(
    .AxiAddrWidth(AxiAddrWidth),
    .QueueDepth  (QueueDepth)
  ) i_queue (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .push_i                   (q_push),
    .addr_i                   (q_addr),
    .len_i                    (q_len),
    .size_i                   (q_size),
    .is_load_i                (axi_ar_valid_o),
    .full_o                   (q_full),
    .ldu_req_ready_i          (ldu_req_ready_i),
    .stu_req_ready_i          (stu_req_ready_i),
    .axi_addrgen_req_valid_o  (axi_addrgen_req_valid_o),
    .axi_addrgen_req_addr_o   (axi_addrgen_req_addr_o),
    .axi_addrgen_req_len_o    (axi_addrgen_req_len_o),
    .axi_addrgen_req_size_o   (axi_addrgen_req_size_o),
    .axi_addrgen_req_is_load_o(axi_addrgen_req_is_load_o)
  );

endmodule

//--- hdl/addr_req_queue.sv
// ======================================
// Burst descriptor queue
// Circular FIFO feeding the load/store units
// ======================================

`timescale 1ns/1ps

module addr_req_queue #(
  parameter int unsigned AxiAddrWidth = 32,
  parameter int unsigned QueueDepth   = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Push side
  input  logic                    push_i,
  input  logic [AxiAddrWidth-1:0] addr_i,
  input  logic [7:0]              len_i,
  input  logic [2:0]              size_i,
  input  logic                    is_load_i,
  output logic                    full_o,
  // Load/store units
  input  logic                    ldu_req_ready_i,
  input  logic                    stu_req_ready_i,
  output logic                    axi_addrgen_req_valid_o,
  output logic [AxiAddrWidth-1:0] axi_addrgen_req_addr_o,
  output logic [7:0]              axi_addrgen_req_len_o,
  output logic [2:0]              axi_addrgen_req_size_o,
  output logic                    axi_addrgen_req_is_load_o
);

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

  // Entry storage
  logic [AxiAddrWidth-1:0] addr_mem    [QueueDepth];
  logic [7:0]              len_mem     [QueueDepth];
  logic [2:0]              size_mem    [QueueDepth];
  logic                    is_load_mem [QueueDepth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                empty, push, pop;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == (PtrWidth + 1)'(QueueDepth));

  assign push = push_i && !full_o;
  // Either unit takes the head entry
  assign pop  = !empty && (ldu_req_ready_i || stu_req_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Count moves only when exactly one side acts
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q]    <= addr_i;
      len_mem[wr_ptr_q]     <= len_i;
      size_mem[wr_ptr_q]    <= size_i;
      is_load_mem[wr_ptr_q] <= is_load_i;
    end
  end

  // Head entry
  assign axi_addrgen_req_valid_o   = !empty;
  assign axi_addrgen_req_addr_o    = addr_mem[rd_ptr_q];
  assign axi_addrgen_req_len_o     = len_mem[rd_ptr_q];
  assign axi_addrgen_req_size_o    = size_mem[rd_ptr_q];
  assign axi_addrgen_req_is_load_o = is_load_mem[rd_ptr_q];

endmodule

//--- hdl/axi_burst_split.sv
// ======================================
// AXI burst splitter
// Cuts a command into page-safe INCR
// bursts and drives them on AR or AW
// ======================================

`timescale 1ns/1ps

module axi_burst_split #(
  parameter int unsigned AxiDataWidth = 64,
  parameter int unsigned AxiAddrWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Command from decode
  input  logic                        cmd_valid_i,
  input  logic [AxiAddrWidth-1:0]     cmd_addr_i,
  input  logic [vls_pkg::VlWidth-1:0] cmd_vl_i,
  input  vls_pkg::vew_e               cmd_vew_i,
  input  logic                        cmd_is_load_i,
  output logic                        cmd_done_o,
  // Scalar core store hazard
  input  logic                        core_st_pending_i,
  // Descriptor queue
  input  logic                        q_full_i,
  output logic                        q_push_o,
  // AR channel
  output logic [AxiAddrWidth-1:0]     axi_ar_addr_o,
  output logic [7:0]                  axi_ar_len_o,
  output logic [2:0]                  axi_ar_size_o,
  output axi_burst_pkg::burst_e       axi_ar_burst_o,
  output logic [3:0]                  axi_ar_cache_o,
  output logic                        axi_ar_valid_o,
  input  logic                        axi_ar_ready_i,
  // AW channel
  output logic [AxiAddrWidth-1:0]     axi_aw_addr_o,
  output logic [7:0]                  axi_aw_len_o,
  output logic [2:0]                  axi_aw_size_o,
  output axi_burst_pkg::burst_e       axi_aw_burst_o,
  output logic [3:0]                  axi_aw_cache_o,
  output logic                        axi_aw_valid_o,
  input  logic                        axi_aw_ready_i
);

  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned SizeBits  = $clog2(BeatBytes);
  localparam int unsigned VlW       = vls_pkg::VlWidth;

  typedef logic [AxiAddrWidth-1:0] addr_t;

  typedef enum logic [1:0] {
    SPLIT_IDLE,
    SPLIT_WAIT,
    SPLIT_REQ
  } state_e;

  state_e state_q, state_d;

  // Current burst address and elements still to request
  addr_t          addr_q, addr_d;
  logic [VlW-1:0] rem_q, rem_d;

  logic done_q, done_d;
  // Valid shown last cycle without a handshake
  logic hold_q;

  addr_t          start_aligned, page_end, beat_end, data_end, last_byte;
  addr_t          beats_m1, nbytes, elems;
  logic [VlW-1:0] consumed;
  logic [7:0]     burst_len;
  logic           ax_valid, ax_ready, xfer, last_burst;

  always_comb begin : burst_calc
    start_aligned = addr_q & ~addr_t'(BeatBytes - 1);
    // End of the current 4 KiB page
    page_end = addr_q | addr_t'((1 << axi_burst_pkg::PageBits) - 1);
    // End of the longest legal burst
    beat_end = start_aligned + addr_t'(axi_burst_pkg::MaxBeats * BeatBytes - 1);
    // Last data byte, rounded to the end of its beat
    data_end = (addr_q + (addr_t'(rem_q) << cmd_vew_i) - addr_t'(1)) | addr_t'(BeatBytes - 1);

    // Smallest of the three limits
    last_byte = page_end;
    if (beat_end < last_byte) begin
      last_byte = beat_end;
    end
    if (data_end < last_byte) begin
      last_byte = data_end;
    end

    beats_m1  = (last_byte - start_aligned) >> SizeBits;
    burst_len = beats_m1[7:0];
    nbytes    = last_byte - addr_q + addr_t'(1);
    elems     = nbytes >> cmd_vew_i;
    consumed  = elems[VlW-1:0];
  end

  // No new valid while the core has a store pending, but a shown one stays up
  assign ax_valid = (state_q == SPLIT_REQ) && !q_full_i && (!core_st_pending_i || hold_q);
  assign ax_ready = cmd_is_load_i ? axi_ar_ready_i : axi_aw_ready_i;
  assign xfer     = ax_valid && ax_ready;

  assign last_burst = (rem_q <= consumed);

  always_comb begin : split_fsm
    state_d = state_q;
    addr_d  = addr_q;
    rem_d   = rem_q;
    done_d  = 1'b0;

    case (state_q)
      SPLIT_IDLE: begin
        // Skip the cycle where decode still shows the finished command
        if (cmd_valid_i && !done_q) begin
          addr_d  = cmd_addr_i;
          rem_d   = cmd_vl_i;
          state_d = core_st_pending_i ? SPLIT_WAIT : SPLIT_REQ;
        end
      end
      SPLIT_WAIT: begin
        if (!core_st_pending_i) begin
          state_d = SPLIT_REQ;
        end
      end
      SPLIT_REQ: begin
        if (xfer) begin
          addr_d = last_byte + addr_t'(1);
          rem_d  = last_burst ? '0 : rem_q - consumed;
          if (last_burst) begin
            done_d  = 1'b1;
            state_d = SPLIT_IDLE;
          end
        end
      end
      default: state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SPLIT_IDLE;
      done_q  <= 1'b0;
      hold_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      hold_q  <= ax_valid && !ax_ready;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    rem_q  <= rem_d;
  end

  assign cmd_done_o = done_q;
  assign q_push_o   = xfer;

  // Both channels carry the same burst, only one valid is raised
  assign axi_ar_valid_o = ax_valid && cmd_is_load_i;
  assign axi_ar_addr_o  = addr_q;
  assign axi_ar_len_o   = burst_len;
  assign axi_ar_size_o  = 3'(SizeBits);
  assign axi_ar_burst_o = axi_burst_pkg::BURST_INCR;
  assign axi_ar_cache_o = axi_burst_pkg::CacheModifiable;

  assign axi_aw_valid_o = ax_valid && !cmd_is_load_i;
  assign axi_aw_addr_o  = addr_q;
  assign axi_aw_len_o   = burst_len;
  assign axi_aw_size_o  = 3'(SizeBits);
  assign axi_aw_burst_o = axi_burst_pkg::BURST_INCR;
  assign axi_aw_cache_o = axi_burst_pkg::CacheModifiable;

endmodule

//--- hdl/vls_req_decode.sv
// ======================================
// Vector memory request decode
// Accepts unit-strided loads and stores,
// checks alignment, issues one command
// ======================================

`timescale 1ns/1ps

module vls_req_decode #(
  parameter int unsigned AxiAddrWidth = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // Sequencer request
  input  logic                               pe_req_valid_i,
  input  logic [$clog2(vls_pkg::NrVInsn)-1:0] pe_req_id_i,
  input  vls_pkg::vls_op_e                   pe_req_op_i,
  input  logic [AxiAddrWidth-1:0]            pe_req_addr_i,
  input  logic [vls_pkg::VlWidth-1:0]        pe_req_vl_i,
  input  vls_pkg::vew_e                      pe_req_vew_i,
  input  logic [vls_pkg::NrVInsn-1:0]        vinsn_running_i,
  // Command to the burst splitter
  input  logic                               cmd_done_i,
  output logic                               cmd_valid_o,
  output logic [AxiAddrWidth-1:0]            cmd_addr_o,
  output logic [vls_pkg::VlWidth-1:0]        cmd_vl_o,
  output vls_pkg::vew_e                      cmd_vew_o,
  output logic                               cmd_is_load_o,
  // Acknowledge to the sequencer
  output logic                               addrgen_ack_o,
  output logic                               addrgen_error_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    REJECT
  } state_e;

  state_e state_q, state_d;

  // Instructions accepted by this stage and not yet cleared
  logic [vls_pkg::NrVInsn-1:0] running_q, running_d;

  // Command registers
  logic [AxiAddrWidth-1:0]     addr_q;
  logic [vls_pkg::VlWidth-1:0] vl_q;
  vls_pkg::vew_e               vew_q;
  logic                        is_load_q;

  logic       new_req;
  logic       unit_stride;
  logic [3:0] elem_mask;
  logic       misaligned;
  logic       accept;

  // Strobes only count in IDLE and for IDs not already running
  assign new_req = pe_req_valid_i && (state_q == IDLE) && !running_q[pe_req_id_i];

  assign unit_stride = (pe_req_op_i == vls_pkg::VLE) || (pe_req_op_i == vls_pkg::VSE);

  // Low address bits must be zero for the element size
  assign elem_mask  = (4'd1 << pe_req_vew_i) - 4'd1;
  assign misaligned = |(pe_req_addr_i[3:0] & elem_mask);
  assign accept     = new_req && unit_stride && !misaligned;

  always_comb begin : decode_fsm
    state_d         = state_q;
    // Drop whatever the sequencer has retired
    running_d       = running_q & vinsn_running_i;
    addrgen_ack_o   = 1'b0;
    addrgen_error_o = 1'b0;

    case (state_q)
      IDLE: begin
        if (accept) begin
          running_d[pe_req_id_i] = 1'b1;
          state_d                = ISSUE;
        end else if (new_req) begin
          state_d = REJECT;
        end
      end
      ISSUE: begin
        // Splitter signals the final burst went out
        if (cmd_done_i) begin
          addrgen_ack_o = 1'b1;
          state_d       = IDLE;
        end
      end
      REJECT: begin
        addrgen_ack_o   = 1'b1;
        addrgen_error_o = 1'b1;
        state_d         = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      running_q <= '0;
    end else begin
      state_q   <= state_d;
      running_q <= running_d;
    end
  end

  // Capture the command on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q    <= pe_req_addr_i;
      vl_q      <= pe_req_vl_i;
      vew_q     <= pe_req_vew_i;
      is_load_q <= (pe_req_op_i == vls_pkg::VLE);
    end
  end

  // Command held until the splitter reports done
  assign cmd_valid_o   = (state_q == ISSUE);
  assign cmd_addr_o    = addr_q;
  assign cmd_vl_o      = vl_q;
  assign cmd_vew_o     = vew_q;
  assign cmd_is_load_o = is_load_q;

endmodule

//--- hdl/axi_burst_pkg.sv
// ======================================
// AXI burst constants
// Burst kinds, page size, beat limit and
// the cache attribute used for bursts
// ======================================

package axi_burst_pkg;

  // AXI burst kinds
  typedef enum logic [1:0] {
    BURST_FIXED,
    BURST_INCR,
    BURST_WRAP
  } burst_e;

  // Bursts must stay inside a 4 KiB page
  localparam int unsigned PageBits = 12;

  // Longest INCR burst allowed by AXI4
  localparam int unsigned MaxBeats = 256;

  // Normal memory, modifiable
  localparam logic [3:0] CacheModifiable = 4'b0010;

endpackage

//--- hdl/vls_pkg.sv
// ======================================
// Vector memory instruction definitions
// Opcodes, element widths and the size of
// the instruction slot table
// ======================================

package vls_pkg;

  // Number of in-flight instruction slots
  localparam int unsigned NrVInsn = 8;

  // Width of the vector length field
  localparam int unsigned VlWidth = 16;

  // Vector memory opcodes
  // Only the unit-strided pair is handled by the address generator
  typedef enum logic [2:0] {
    VLE,
    VSE,
    VLSE,
    VSSE,
    VLXE,
    VSXE,
    VNOP
  } vls_op_e;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

endpackage
